//--- verilog/icache_pkg.sv
package icache_pkg;

    localparam int LINE_WORDS = 8;
    localparam int NR_SETS    = 64;
    localparam int NR_WAYS    = 2;

    // address split into tag | index | word offset | byte
    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB  = 5;
    localparam int TAG_LSB    = 11;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [20:0] tag_t;
    typedef logic [5:0]  index_t;
    typedef logic [2:0]  offset_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        logic  uncached;
    } fetch_req_t;

    typedef struct packed {
        logic  hit;
        word_t data;
    } way_rd_t;

    typedef struct packed {
        logic    en;
        logic    tag_we;
        index_t  index;
        offset_t offset;
        tag_t    tag;
        word_t   data;
    } way_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        BYPASS,
        FINISH
    } refill_state_e;

    function automatic tag_t addr_tag(addr_t a);
        return a[31:TAG_LSB];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[TAG_LSB-1:INDEX_LSB];
    endfunction

    function automatic offset_t addr_offset(addr_t a);
        return a[INDEX_LSB-1:OFFSET_LSB];
    endfunction

    function automatic addr_t line_addr(addr_t a);
        return {a[31:INDEX_LSB], {INDEX_LSB{1'b0}}};
    endfunction

endpackage

//--- verilog/icache_lookup.sv
`timescale 1ns/100ps

module icache_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_req_valid,
    input  icache_pkg::addr_t      i_req_addr,
    input  logic                   i_req_uncached,
    input  logic                   i_hold,
    input  logic                   i_stall,
    output icache_pkg::fetch_req_t o_s1_req,
    output logic                   o_rd_en,
    output icache_pkg::index_t     o_rd_index,
    output icache_pkg::offset_t    o_rd_offset
);
    import icache_pkg::*;

    logic  advance;
    logic  s1_valid;
    addr_t s1_addr;
    logic  s1_uncached;

    // stage moves only when neither the cache nor the core holds it
    assign advance = ~i_stall & ~i_hold;

    // arrays read the incoming address so their output lines up with s1
    assign o_rd_en     = advance;
    assign o_rd_index  = addr_index(i_req_addr);
    assign o_rd_offset = addr_offset(i_req_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= i_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && i_req_valid) begin
            s1_addr     <= i_req_addr;
            s1_uncached <= i_req_uncached;
        end
    end

    assign o_s1_req = '{
        valid:    s1_valid,
        addr:     s1_addr,
        uncached: s1_uncached
    };

endmodule

//--- verilog/icache_way.sv
`timescale 1ns/100ps

module icache_way (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rd_en,
    input  icache_pkg::index_t  i_rd_index,
    input  icache_pkg::offset_t i_rd_offset,
    input  icache_pkg::tag_t    i_cmp_tag,
    input  icache_pkg::way_wr_t i_wr,
    input  logic                i_wr_sel,
    output icache_pkg::way_rd_t o_rd
);
    import icache_pkg::*;

    tag_t               tag_mem [NR_SETS];
    word_t              data_mem [NR_SETS*LINE_WORDS];
    logic [NR_SETS-1:0] valid;

    tag_t  rd_tag_q;
    word_t rd_word_q;
    logic  rd_valid_q;
    logic  wr_fire;

    assign wr_fire = i_wr_sel & i_wr.en;

    // arrays written by refill beats
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            data_mem[{i_wr.index, i_wr.offset}] <= i_wr.data;
            if (i_wr.tag_we) begin
                tag_mem[i_wr.index] <= i_wr.tag;
            end
        end
    end

    // synchronous read frozen while the pipeline stalls
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            rd_tag_q  <= tag_mem[i_rd_index];
            rd_word_q <= data_mem[{i_rd_index, i_rd_offset}];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            // line becomes valid together with its tag on the last beat
            if (wr_fire && i_wr.tag_we) begin
                valid[i_wr.index] <= 1'b1;
            end
            if (i_rd_en) begin
                rd_valid_q <= valid[i_rd_index];
            end
        end
    end

    assign o_rd = '{
        hit:  rd_valid_q & (rd_tag_q == i_cmp_tag),
        data: rd_word_q
    };

endmodule

//--- verilog/icache_refill.sv
`timescale 1ns/100ps

module icache_refill (
    input  logic                            clk,
    input  logic                            rst,
    input  icache_pkg::fetch_req_t          i_s1_req,
    input  icache_pkg::way_rd_t             i_way_rd [icache_pkg::NR_WAYS],
    input  logic                            i_hold,
    output logic                            o_stall,
    output logic                            o_rsp_valid,
    output icache_pkg::word_t               o_rsp_data,
    output icache_pkg::way_wr_t             o_wr,
    output logic [icache_pkg::NR_WAYS-1:0]  o_wr_sel,
    output icache_pkg::addr_t               o_araddr,
    output logic [7:0]                      o_arlen,
    output logic [2:0]                      o_arsize,
    output logic                            o_arvalid,
    input  logic                            i_arready,
    input  icache_pkg::word_t               i_rdata,
    input  logic                            i_rlast,
    input  logic                            i_rvalid,
    output logic                            o_rready
);
    import icache_pkg::*;

    refill_state_e      state;
    logic [NR_SETS-1:0] lru;
    logic               victim;
    offset_t            beat;
    word_t              crit_word;

    logic    hit_any;
    logic    hit_way;
    word_t   hit_word;
    index_t  s1_index;
    offset_t s1_offset;
    logic    s1_hit;
    logic    s1_miss;
    logic    beat_fire;

    assign s1_index  = addr_index(i_s1_req.addr);
    assign s1_offset = addr_offset(i_s1_req.addr);

    // way select
    always_comb begin
        hit_any  = 1'b0;
        hit_way  = 1'b0;
        hit_word = i_way_rd[0].data;
        for (int w = 0; w < NR_WAYS; w++) begin
            if (i_way_rd[w].hit) begin
                hit_any  = 1'b1;
                hit_way  = w[0];
                hit_word = i_way_rd[w].data;
            end
        end
    end

    assign s1_hit  = i_s1_req.valid & ~i_s1_req.uncached & hit_any;
    assign s1_miss = i_s1_req.valid & (i_s1_req.uncached | ~hit_any);

    assign o_stall     = (state == IDLE) ? s1_miss : (state != FINISH);
    assign o_rsp_valid = (state == FINISH) | ((state == IDLE) & s1_hit);
    assign o_rsp_data  = (state == FINISH) ? crit_word : hit_word;

    assign beat_fire = i_rvalid & o_rready;
    assign o_arsize  = 3'd2;

    // every refill beat goes into the victim way with the tag on the last one
    assign o_wr = '{
        en:     (state == REFILL) & beat_fire,
        tag_we: (state == REFILL) & beat_fire & i_rlast,
        index:  s1_index,
        offset: beat,
        tag:    addr_tag(i_s1_req.addr),
        data:   i_rdata
    };

    always_comb begin
        for (int w = 0; w < NR_WAYS; w++) begin
            o_wr_sel[w] = (victim == w[0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            lru       <= '0;
            victim    <= 1'b0;
            beat      <= '0;
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_s1_req.valid && i_s1_req.uncached) begin
                        o_arvalid <= 1'b1;
                        state     <= BYPASS;
                    end else if (s1_miss) begin
                        // fill the lru way so the other one becomes next victim
                        victim        <= lru[s1_index];
                        lru[s1_index] <= ~lru[s1_index];
                        beat          <= '0;
                        o_arvalid     <= 1'b1;
                        state         <= REFILL;
                    end else if (s1_hit && !i_hold) begin
                        lru[s1_index] <= ~hit_way;
                    end
                end
                REFILL, BYPASS: begin
                    if (o_arvalid && i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                    end
                    if (beat_fire) begin
                        beat <= beat + 1'b1;
                        if (i_rlast) begin
                            o_rready <= 1'b0;
                            state    <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    // response stays up until the core takes it
                    if (!i_hold) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request address and critical word
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (i_s1_req.uncached) begin
                o_araddr <= i_s1_req.addr;
                o_arlen  <= 8'd0;
            end else begin
                o_araddr <= line_addr(i_s1_req.addr);
                o_arlen  <= 8'(LINE_WORDS - 1);
            end
        end
        if (beat_fire && (state == BYPASS || beat == s1_offset)) begin
            crit_word <= i_rdata;
        end
    end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req_valid,
    input  icache_pkg::addr_t i_req_addr,
    input  logic              i_req_uncached,
    input  logic              i_hold,
    output logic              o_stall,
    output logic              o_rsp_valid,
    output icache_pkg::word_t o_rsp_data,
    output icache_pkg::addr_t o_araddr,
    output logic [7:0]        o_arlen,
    output logic [2:0]        o_arsize,
    output logic              o_arvalid,
    input  logic              i_arready,
    input  icache_pkg::word_t i_rdata,
    input  logic              i_rlast,
    input  logic              i_rvalid,
    output logic              o_rready
);
    import icache_pkg::*;

    fetch_req_t         s1_req;
    logic               rd_en;
    index_t             rd_index;
    offset_t            rd_offset;
    tag_t               cmp_tag;
    way_rd_t            way_rd [NR_WAYS];
    way_wr_t            wr;
    logic [NR_WAYS-1:0] wr_sel;

    assign cmp_tag = addr_tag(s1_req.addr);

    icache_lookup i_lookup (
        .clk            (clk),
        .rst            (rst),
        .i_req_valid    (i_req_valid),
        .i_req_addr     (i_req_addr),
        .i_req_uncached (i_req_uncached),
        .i_hold         (i_hold),
        .i_stall        (o_stall),
        .o_s1_req       (s1_req),
        .o_rd_en        (rd_en),
        .o_rd_index     (rd_index),
        .o_rd_offset    (rd_offset)
    );

    for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
        icache_way i_way (
            .clk         (clk),
            .rst         (rst),
            .i_rd_en     (rd_en),
            .i_rd_index  (rd_index),
            .i_rd_offset (rd_offset),
            .i_cmp_tag   (cmp_tag),
            .i_wr        (wr),
            .i_wr_sel    (wr_sel[w]),
            .o_rd        (way_rd[w])
        );
    end

    icache_refill i_refill (
        .clk         (clk),
        .rst         (rst),
        .i_s1_req    (s1_req),
        .i_way_rd    (way_rd),
        .i_hold      (i_hold),
        .o_stall     (o_stall),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_data  (o_rsp_data),
        .o_wr        (wr),
        .o_wr_sel    (wr_sel),
        .o_araddr    (o_araddr),
        .o_arlen     (o_arlen),
        .o_arsize    (o_arsize),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .i_rdata     (i_rdata),
        .i_rlast     (i_rlast),
        .i_rvalid    (i_rvalid),
        .o_rready    (o_rready)
    );

endmodule

//--- test/icache_sva.sv
`timescale 1ns/100ps

module icache_sva (
    input logic              clk,
    input logic              rst,
    input logic              i_arvalid,
    input logic              i_arready,
    input icache_pkg::addr_t i_araddr,
    input logic              i_rready,
    input logic              i_rsp_valid
);

    int fail_count = 0;

    // address request held until accepted
    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr)
    ) else begin
        fail_count++;
        $error("o_arvalid dropped or o_araddr changed before i_arready");
    end

    a_rready_after_ar: assert property (
        @(posedge clk) disable iff (rst)
        !(i_rready && i_arvalid)
    ) else begin
        fail_count++;
        $error("o_rready high while o_arvalid is still pending");
    end

    // a new miss never starts under a response
    a_rsp_not_on_ar: assert property (
        @(posedge clk) disable iff (rst)
        !(i_rsp_valid && $rose(i_arvalid))
    ) else begin
        fail_count++;
        $error("o_rsp_valid coincides with a rising o_arvalid");
    end

endmodule

//--- test/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NR_REQS    = 440;

    logic       clk = 1'b0;
    logic       rst;
    logic       i_req_valid;
    addr_t      i_req_addr;
    logic       i_req_uncached;
    logic       i_hold;
    logic       o_stall;
    logic       o_rsp_valid;
    word_t      o_rsp_data;
    addr_t      o_araddr;
    logic [7:0] o_arlen;
    logic [2:0] o_arsize;
    logic       o_arvalid;
    logic       i_arready;
    word_t      i_rdata;
    logic       i_rlast;
    logic       i_rvalid;
    logic       o_rready;

    // scoreboard state kept by the response checker
    addr_t      exp_q[$];
    int         rsp_errors = 0;
    int         rsp_checks = 0;
    int         cycle = 0;
    int         last_rsp_cycle = -2;
    int         b2b = 0;

    // memory model side
    int         ar_count = 0;
    addr_t      last_araddr;
    logic [7:0] last_arlen;
    logic [2:0] last_arsize;

    // stimulus side
    int         errors = 0;
    int         checks = 0;
    int         test_errors = 0;
    logic       hold_rand;

    icache_top i_dut (.*);

    bind icache_top icache_sva i_sva (
        .clk         (clk),
        .rst         (rst),
        .i_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .i_araddr    (o_araddr),
        .i_rready    (o_rready),
        .i_rsp_valid (o_rsp_valid)
    );

    // memory contents derived from the word address
    function automatic word_t mem_word(addr_t a);
        return (a >> 2) ^ 32'hC0DE0000;
    endfunction

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NR_REQS * 64 * CLK_PERIOD);
        $display("timeout: fetches still outstanding after %0d cycles", NR_REQS * 64);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // AXI slave with random address accept and data gaps
    initial begin
        addr_t base;
        int    beats;
        i_arready = 1'b0;
        i_rvalid  = 1'b0;
        i_rlast   = 1'b0;
        i_rdata   = '0;
        forever begin
            @(posedge clk);
            if (!rst && o_arvalid && i_arready) begin
                base        = o_araddr;
                beats       = int'(o_arlen) + 1;
                last_araddr = o_araddr;
                last_arlen  = o_arlen;
                last_arsize = o_arsize;
                ar_count++;
                #1;
                i_arready = 1'b0;
                for (int b = 0; b < beats; b++) begin
                    while ($urandom_range(3) == 0) begin
                        i_rvalid = 1'b0;
                        @(posedge clk);
                        #1;
                    end
                    i_rvalid = 1'b1;
                    i_rdata  = mem_word(base + 4 * b);
                    i_rlast  = (b == beats - 1);
                    @(posedge clk);
                    while (!o_rready) begin
                        @(posedge clk);
                    end
                    #1;
                end
                i_rvalid = 1'b0;
                i_rlast  = 1'b0;
            end else begin
                #1;
                i_arready = ($urandom_range(2) == 0);
            end
        end
    end

    // record accepted fetches and compare responses in order
    always @(posedge clk) begin
        addr_t a;
        cycle++;
        if (!rst) begin
            if (o_rsp_valid && !i_hold) begin
                assert (exp_q.size() != 0) else begin
                    rsp_errors++;
                    $display("response arrived with no fetch outstanding");
                end
                if (exp_q.size() != 0) begin
                    a = exp_q.pop_front();
                    rsp_checks++;
                    assert (o_rsp_data == mem_word(a)) else begin
                        rsp_errors++;
                        $display("ERROR o_rsp_data: got %h, expected %h, addr %h",
                                 o_rsp_data, mem_word(a), a);
                    end
                end
                if (last_rsp_cycle == cycle - 1) begin
                    b2b++;
                end
                last_rsp_cycle = cycle;
            end
            if (i_req_valid && !o_stall && !i_hold) begin
                exp_q.push_back(i_req_addr);
            end
        end
    end

    task automatic after_edge();
        #1;
        if (hold_rand) begin
            i_hold = ($urandom_range(3) == 0);
        end
    endtask

    task automatic fetch(input addr_t a, input logic unc);
        logic taken;
        i_req_valid    = 1'b1;
        i_req_addr     = a;
        i_req_uncached = unc;
        taken          = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = !o_stall && !i_hold;
            after_edge();
        end
        i_req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            after_edge();
        end
    endtask

    task automatic fetch_bursts(input addr_t a, input logic unc, input int nr_ar);
        int start;
        start = ar_count;
        fetch(a, unc);
        drain();
        checks++;
        assert (ar_count - start == nr_ar) else begin
            errors++;
            $display("ERROR o_arvalid handshakes for addr %h: got %h, expected %h",
                     a, ar_count - start, nr_ar);
        end
    endtask

    task automatic check_ar(input addr_t addr, input logic [7:0] len);
        checks++;
        assert (last_araddr == addr && last_arlen == len && last_arsize == 3'd2) else begin
            errors++;
            $display("ERROR o_araddr/o_arlen/o_arsize: got %h/%h/%h, expected %h/%h/2",
                     last_araddr, last_arlen, last_arsize, addr, len);
        end
    endtask

    task automatic report(input string name);
        $display("%s: %0d errors", name, errors + rsp_errors - test_errors);
        test_errors = errors + rsp_errors;
    endtask

    initial begin
        word_t held_data;
        int    b2b_start;
        int    total;
        void'($urandom(32'h24905ded));
        rst            = 1'b1;
        i_req_valid    = 1'b0;
        i_req_addr     = '0;
        i_req_uncached = 1'b0;
        i_hold         = 1'b0;
        hold_rand      = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // miss lands on word 5 and the rest of the line must hit
        fetch_bursts(32'h0000_0414, 1'b0, 1);
        check_ar(32'h0000_0400, 8'd7);
        for (int w = 0; w < LINE_WORDS; w++) begin
            if (w != 5) begin
                fetch_bursts(32'h400 + 4 * w, 1'b0, 0);
            end
        end
        report("cold miss then hits");

        // A, B and C all in set 2
        fetch_bursts(32'h1040, 1'b0, 1);
        fetch_bursts(32'h1840, 1'b0, 1);
        fetch_bursts(32'h1044, 1'b0, 0);
        fetch_bursts(32'h2040, 1'b0, 1);
        fetch_bursts(32'h1048, 1'b0, 0);
        fetch_bursts(32'h1844, 1'b0, 1);
        report("two ways and lru");

        fetch_bursts(32'h104C, 1'b1, 1);
        check_ar(32'h104C, 8'd0);
        fetch_bursts(32'h104C, 1'b0, 0);
        fetch_bursts(32'h7000_0008, 1'b1, 1);
        check_ar(32'h7000_0008, 8'd0);
        report("uncached bypass");

        b2b_start = b2b;
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(32'h400 + 4 * w, 1'b0);
        end
        drain();
        checks++;
        assert (b2b - b2b_start == LINE_WORDS - 1) else begin
            errors++;
            $display("ERROR o_rsp_valid consecutive responses: got %h, expected %h",
                     b2b - b2b_start, LINE_WORDS - 1);
        end
        // next fetch waits behind the held response
        fetch(32'h408, 1'b0);
        i_hold         = 1'b1;
        held_data      = mem_word(32'h408);
        i_req_valid    = 1'b1;
        i_req_addr     = 32'h40C;
        i_req_uncached = 1'b0;
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #1;
            checks++;
            assert (o_rsp_valid && o_rsp_data == held_data) else begin
                errors++;
                $display("ERROR o_rsp_valid/o_rsp_data under hold: got %h/%h, expected 1/%h",
                         o_rsp_valid, o_rsp_data, held_data);
            end
        end
        i_hold = 1'b0;
        fetch(32'h40C, 1'b0);
        drain();
        report("back-to-back hits and hold");

        hold_rand = 1'b1;
        for (int n = 0; n < 400; n++) begin
            fetch(addr_t'($urandom_range(4095)) << 2, ($urandom_range(9) == 0));
            if ($urandom_range(3) == 0) begin
                @(posedge clk);
                after_edge();
            end
        end
        drain();
        hold_rand = 1'b0;
        i_hold    = 1'b0;
        report("random mix");

        total = errors + rsp_errors + i_dut.i_sva.fail_count;
        $display("checks %0d, errors %0d", checks + rsp_checks, total);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- icache_top.f
verilog/icache_pkg.sv
verilog/icache_lookup.sv
verilog/icache_way.sv
verilog/icache_refill.sv
verilog/icache_top.sv
test/icache_sva.sv
test/icache_tb.sv

//--- Makefile
TOOL     := verilator
TOP      := icache_tb
FILELIST := icache_top.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
SIM_ARGS := +verilator+error+limit+100
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
